// File: Bender.yml
package:
  name: gat_attn

sources:
  - rtl/gat_pkg.sv
  - rtl/gat_apb_regs.sv
  - rtl/gat_score_unit.sv
  - rtl/gat_coef_combine.sv
  - rtl/gat_attn_top.sv
  - target: simulation
    files:
      - sim/gat_attn_tb.sv

// File: rtl/gat_apb_regs.sv
`timescale 1ns/1ps

module gat_apb_regs
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [APB_AW-1:0]             paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [31:0]                   pwdata_i,
  output logic [31:0]                   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  input  logic                          coef_fire_i,

  output logic [NUM_FEATURE*FEAT_W-1:0] a_self_o,
  output logic [NUM_FEATURE*FEAT_W-1:0] a_neigh_o,
  output logic                          ctrl_en_o
);

  localparam int IDX_W = $clog2(MAX_FEATURE);

  logic [NUM_FEATURE-1:0][FEAT_W-1:0] a_self_q;
  logic [NUM_FEATURE-1:0][FEAT_W-1:0] a_neigh_q;
  logic                               ctrl_en_q;
  logic [31:0]                        count_q;

  reg_sel_e         reg_sel;
  logic [IDX_W-1:0] idx;
  logic             access;
  logic             wr_en;

  // ======================================================================
  // Address decode
  // ======================================================================
  assign idx    = paddr_i[2 +: IDX_W];
  assign access = psel_i && penable_i;

  always_comb begin
    reg_sel = REG_BAD;
    if (paddr_i[1:0] == 2'b00) begin
      if (paddr_i < A_NEIGH_BASE) begin
        if (idx < NUM_FEATURE) reg_sel = REG_A_SELF;
      end else if (paddr_i < CTRL_ADDR) begin
        if (idx < NUM_FEATURE) reg_sel = REG_A_NEIGH;
      end else if (paddr_i == CTRL_ADDR) begin
        reg_sel = REG_CTRL;
      end else if (paddr_i == COUNT_ADDR) begin
        reg_sel = REG_COUNT;
      end
    end
  end

  // Writing the read-only count is an error
  assign pslverr_o = access && (reg_sel == REG_BAD || (pwrite_i && reg_sel == REG_COUNT));
  assign pready_o  = 1'b1;
  assign wr_en     = access && pwrite_i && !pslverr_o;

  // ======================================================================
  // Registers
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_self_q  <= '0;
      a_neigh_q <= '0;
      ctrl_en_q <= 1'b0;
    end else if (wr_en) begin
      case (reg_sel)
        REG_A_SELF:  a_self_q[idx]  <= pwdata_i[FEAT_W-1:0];
        REG_A_NEIGH: a_neigh_q[idx] <= pwdata_i[FEAT_W-1:0];
        REG_CTRL:    ctrl_en_q      <= pwdata_i[0];
        default:     ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (coef_fire_i) begin
      count_q <= count_q + 32'd1;
    end
  end

  // Entries read back sign-extended
  always_comb begin
    prdata_o = '0;
    if (access) begin
      case (reg_sel)
        REG_A_SELF:  prdata_o = {{(32-FEAT_W){a_self_q[idx][FEAT_W-1]}}, a_self_q[idx]};
        REG_A_NEIGH: prdata_o = {{(32-FEAT_W){a_neigh_q[idx][FEAT_W-1]}}, a_neigh_q[idx]};
        REG_CTRL:    prdata_o = {31'd0, ctrl_en_q};
        REG_COUNT:   prdata_o = count_q;
        default:     prdata_o = '0;
      endcase
    end
  end

  assign a_self_o  = a_self_q;
  assign a_neigh_o = a_neigh_q;
  assign ctrl_en_o = ctrl_en_q;

  // No wait states, so every access phase follows its own setup phase
  assert property (@(posedge clk) disable iff (!rst_n)
    penable_i |-> $past(psel_i && !penable_i));

endmodule

// File: rtl/gat_attn_top.sv
`timescale 1ns/1ps

module gat_attn_top
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // APB
  input  logic [APB_AW-1:0]             paddr_i,
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [31:0]                   pwdata_i,
  output logic [31:0]                   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,

  // Edge input stream
  input  logic                          edge_valid_i,
  input  logic [NUM_FEATURE*FEAT_W-1:0] edge_self_i,
  input  logic [NUM_FEATURE*FEAT_W-1:0] edge_neigh_i,
  output logic                          edge_ready_o,

  // Coefficient output stream
  output logic                          coef_valid_o,
  output logic signed [SCORE_W-1:0]     coef_o,
  input  logic                          coef_ready_i
);

  logic [NUM_FEATURE*FEAT_W-1:0] a_self;
  logic [NUM_FEATURE*FEAT_W-1:0] a_neigh;
  logic                          ctrl_en;
  logic                          pipe_adv;
  logic                          coef_fire;
  logic                          self_valid;
  logic signed [SCORE_W-1:0]     self_score;
  logic                          neigh_valid;
  logic signed [SCORE_W-1:0]     neigh_score;

  // ======================================================================
  // Register bank
  // ======================================================================
  gat_apb_regs #(
    .NUM_FEATURE (NUM_FEATURE)
  ) u_apb_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .coef_fire_i (coef_fire),
    .a_self_o    (a_self),
    .a_neigh_o   (a_neigh),
    .ctrl_en_o   (ctrl_en)
  );

  // ======================================================================
  // Score units and combiner
  // ======================================================================
  gat_score_unit #(
    .NUM_FEATURE (NUM_FEATURE)
  ) u_self_score (
    .clk           (clk),
    .rst_n         (rst_n),
    .pipe_adv_i    (pipe_adv),
    .edge_valid_i  (edge_valid_i),
    .edge_ready_i  (edge_ready_o),
    .feat_i        (edge_self_i),
    .attn_i        (a_self),
    .score_valid_o (self_valid),
    .score_o       (self_score)
  );

  gat_score_unit #(
    .NUM_FEATURE (NUM_FEATURE)
  ) u_neigh_score (
    .clk           (clk),
    .rst_n         (rst_n),
    .pipe_adv_i    (pipe_adv),
    .edge_valid_i  (edge_valid_i),
    .edge_ready_i  (edge_ready_o),
    .feat_i        (edge_neigh_i),
    .attn_i        (a_neigh),
    .score_valid_o (neigh_valid),
    .score_o       (neigh_score)
  );

  gat_coef_combine #(
    .NUM_FEATURE (NUM_FEATURE)
  ) u_coef_combine (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_en_i     (ctrl_en),
    .self_valid_i  (self_valid),
    .self_score_i  (self_score),
    .neigh_valid_i (neigh_valid),
    .neigh_score_i (neigh_score),
    .coef_ready_i  (coef_ready_i),
    .pipe_adv_o    (pipe_adv),
    .edge_ready_o  (edge_ready_o),
    .coef_valid_o  (coef_valid_o),
    .coef_o        (coef_o),
    .coef_fire_o   (coef_fire)
  );

endmodule

// File: rtl/gat_coef_combine.sv
`timescale 1ns/1ps

module gat_coef_combine
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE = 4
) (
  input  logic                      clk,
  input  logic                      rst_n,

  input  logic                      ctrl_en_i,
  input  logic                      self_valid_i,
  input  logic signed [SCORE_W-1:0] self_score_i,
  input  logic                      neigh_valid_i,
  input  logic signed [SCORE_W-1:0] neigh_score_i,
  input  logic                      coef_ready_i,

  output logic                      pipe_adv_o,
  output logic                      edge_ready_o,
  output logic                      coef_valid_o,
  output logic signed [SCORE_W-1:0] coef_o,
  output logic                      coef_fire_o
);

  if (NUM_FEATURE < 1 || NUM_FEATURE > MAX_FEATURE) begin : g_bad_num_feature
    $error("NUM_FEATURE must lie between 1 and MAX_FEATURE");
  end

  logic signed [SCORE_W:0]   sum;
  logic signed [SCORE_W:0]   lrelu;
  logic                      coef_valid_q;
  logic signed [SCORE_W-1:0] coef_q;

  // Whole pipeline moves when the output slot is free or being taken
  assign pipe_adv_o   = !coef_valid_q || coef_ready_i;
  assign edge_ready_o = pipe_adv_o && ctrl_en_i;

  // LeakyReLU on the combined score
  assign sum   = self_score_i + neigh_score_i;
  assign lrelu = sum[SCORE_W] ? (sum >>> LRELU_SHIFT) : sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      coef_valid_q <= 1'b0;
    end else if (pipe_adv_o) begin
      coef_valid_q <= self_valid_i && neigh_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_adv_o) coef_q <= lrelu[SCORE_W-1:0];
  end

  assign coef_valid_o = coef_valid_q;
  assign coef_o       = coef_q;
  assign coef_fire_o  = coef_valid_q && coef_ready_i;

  // Both score units share one advance, so they stay in lockstep
  assert property (@(posedge clk) disable iff (!rst_n) self_valid_i == neigh_valid_i);

  assert property (@(posedge clk) disable iff (!rst_n)
    coef_valid_o && !coef_ready_i |=> $stable(coef_o));

endmodule

// File: rtl/gat_pkg.sv
package gat_pkg;

  // ======================================================================
  // Data widths
  // ======================================================================
  localparam int FEAT_W  = 8;
  localparam int PROD_W  = 16;
  // Room for the sum of up to MAX_FEATURE products
  localparam int SCORE_W = 20;

  localparam int MAX_FEATURE = 16;

  // Negative slope of LeakyReLU is 2^-LRELU_SHIFT
  localparam int LRELU_SHIFT = 3;

  // ======================================================================
  // APB register map
  // ======================================================================
  localparam int APB_AW = 8;

  // Self half starts at byte 0x00 and the neighbour half follows it
  localparam logic [APB_AW-1:0] A_NEIGH_BASE = APB_AW'(4 * MAX_FEATURE);
  localparam logic [APB_AW-1:0] CTRL_ADDR    = APB_AW'(8 * MAX_FEATURE);
  localparam logic [APB_AW-1:0] COUNT_ADDR   = APB_AW'(8 * MAX_FEATURE + 4);

  typedef enum logic [2:0] {
    REG_A_SELF,
    REG_A_NEIGH,
    REG_CTRL,
    REG_COUNT,
    REG_BAD
  } reg_sel_e;

endpackage

// File: rtl/gat_score_unit.sv
`timescale 1ns/1ps

module gat_score_unit
  import gat_pkg::*;
#(
  parameter int NUM_FEATURE = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          pipe_adv_i,
  input  logic                          edge_valid_i,
  input  logic                          edge_ready_i,
  input  logic [NUM_FEATURE*FEAT_W-1:0] feat_i,
  input  logic [NUM_FEATURE*FEAT_W-1:0] attn_i,

  output logic                          score_valid_o,
  output logic signed [SCORE_W-1:0]     score_o
);

  logic signed [PROD_W-1:0]  prod_q [NUM_FEATURE];
  logic                      prod_valid_q;
  logic signed [SCORE_W-1:0] sum_d;
  logic signed [SCORE_W-1:0] sum_q;
  logic                      sum_valid_q;

  // ======================================================================
  // Stage 1 element-wise products
  // ======================================================================
  always_ff @(posedge clk) begin
    if (pipe_adv_i) begin
      for (int i = 0; i < NUM_FEATURE; i++) begin
        prod_q[i] <= $signed(feat_i[i*FEAT_W +: FEAT_W]) *
                     $signed(attn_i[i*FEAT_W +: FEAT_W]);
      end
    end
  end

  // ======================================================================
  // Stage 2 adder tree
  // ======================================================================
  always_comb begin
    sum_d = '0;
    for (int i = 0; i < NUM_FEATURE; i++) begin
      sum_d = sum_d + prod_q[i];
    end
  end

  always_ff @(posedge clk) begin
    if (pipe_adv_i) sum_q <= sum_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid_q <= 1'b0;
      sum_valid_q  <= 1'b0;
    end else if (pipe_adv_i) begin
      prod_valid_q <= edge_valid_i && edge_ready_i;
      sum_valid_q  <= prod_valid_q;
    end
  end

  assign score_valid_o = sum_valid_q;
  assign score_o       = sum_q;

  assert property (@(posedge clk) disable iff (!rst_n)
    !pipe_adv_i |=> $stable(score_valid_o));

endmodule

// File: sim/gat_attn_cases.txt
# W addr data err | R addr data err | C (count read) | addr, data, err in hex
# E s0 s1 s2 s3 n0 n1 n2 n3 coef | H s0..n3 (blocked edge) | entries, coef in decimal
W 00 00000001 0
W 04 00000002 0
W 08 000000fd 0
W 0c 00000004 0
W 40 000000ff 0
W 44 00000005 0
W 48 00000000 0
W 4c 000000fe 0
R 08 fffffffd 0
R 4c fffffffe 0
R 44 00000005 0
W 80 00000001 0
R 80 00000001 0
E 1 1 1 1 1 1 1 1 6
E 10 -5 3 0 2 4 100 1 7
E -10 0 0 -20 3 -2 7 1 -14
E 0 0 5 0 0 0 0 0 -2
E 0 0 0 0 0 0 0 0 0
E -1 0 0 0 0 0 0 0 -1
E 127 127 -128 127 -128 127 -128 -128 2292
# Extreme attention entries
W 00 0000007f 0
W 04 00000080 0
W 08 0000007f 0
W 0c 00000080 0
W 40 00000080 0
W 44 00000080 0
W 48 00000080 0
W 4c 00000080 0
R 04 ffffff80 0
E 127 -128 127 -128 -128 -128 -128 -128 130562
E -128 127 -128 127 127 127 127 127 -16256
E 1 0 0 0 0 0 0 -1 255
E 0 1 0 0 0 0 0 0 -16
E 0 0 -1 0 0 0 0 0 -16
C
# Enable cleared, then bus errors
W 80 00000000 0
R 80 00000000 0
H 1 1 1 1 1 1 1 1
C
R 10 00000000 1
R 50 00000000 1
R 88 00000000 1
R 02 00000000 1
W 84 00000055 1
R 84 0000000c 0

// File: sim/gat_attn_tb.sv
`timescale 1ns/1ps

module gat_attn_tb
  import gat_pkg::*;
();

  localparam int NUM_FEATURE  = 4;
  localparam int VEC_W        = NUM_FEATURE * FEAT_W;
  localparam int TIMEOUT      = 200;
  localparam int BLOCK_CYCLES = 20;

  logic                      clk;
  logic                      rst_n;
  logic [APB_AW-1:0]         paddr_i;
  logic                      psel_i;
  logic                      penable_i;
  logic                      pwrite_i;
  logic [31:0]               pwdata_i;
  logic [31:0]               prdata_o;
  logic                      pready_o;
  logic                      pslverr_o;
  logic                      edge_valid_i;
  logic [VEC_W-1:0]          edge_self_i;
  logic [VEC_W-1:0]          edge_neigh_i;
  logic                      edge_ready_o;
  logic                      coef_valid_o;
  logic signed [SCORE_W-1:0] coef_o;
  logic                      coef_ready_i;

  logic [2*VEC_W-1:0]        edge_q [$];
  int                        exp_q [$];
  int                        errors = 0;
  int                        rx_count = 0;
  integer                    seed = 32'hb757_ecc1;
  logic                      hold_valid = 1'b0;
  logic signed [SCORE_W-1:0] hold_value;

  gat_attn_top #(
    .NUM_FEATURE (NUM_FEATURE)
  ) u_gat_attn_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .edge_valid_i (edge_valid_i),
    .edge_self_i  (edge_self_i),
    .edge_neigh_i (edge_neigh_i),
    .edge_ready_o (edge_ready_o),
    .coef_valid_o (coef_valid_o),
    .coef_o       (coef_o),
    .coef_ready_i (coef_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Random back-pressure
  always begin
    @(posedge clk);
    #1;
    coef_ready_i = ($random(seed) % 2) != 0;
  end

  // A held coefficient must not change
  always @(posedge clk) begin
    if (rst_n && hold_valid && coef_o !== hold_value) begin
      report_mismatch("coef_o (held)", hold_value, coef_o);
    end
    hold_valid = coef_valid_o && !coef_ready_i;
    hold_value = coef_o;
  end

  // ======================================================================
  // Reporting
  // ======================================================================
  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("[ERROR] %0t ns: %s expected %0d, actual %0d", $time, name, exp, act);
    errors++;
  endtask

  task automatic log_failure(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    errors++;
  endtask

  // ======================================================================
  // Bus and stream drivers
  // ======================================================================
  task automatic apb_access(input logic write, input logic [APB_AW-1:0] addr,
                            input logic [31:0] wdata, input logic [31:0] exp_data,
                            input logic exp_err);
    int wait_cnt;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge clk);
    #1;
    penable_i = 1'b1;
    wait_cnt  = 0;
    do begin
      @(posedge clk);
      wait_cnt++;
    end while (!pready_o && wait_cnt < TIMEOUT);
    if (!pready_o) begin
      log_failure("APB access never saw pready_o");
    end else begin
      if (!write && prdata_o !== exp_data) report_mismatch("prdata_o", exp_data, prdata_o);
      if (pslverr_o !== exp_err) report_mismatch("pslverr_o", exp_err, pslverr_o);
    end
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic send_edges();
    int wait_cnt;
    while (edge_q.size() > 0) begin
      {edge_self_i, edge_neigh_i} = edge_q[0];
      edge_valid_i = 1'b1;
      wait_cnt     = 0;
      do begin
        @(posedge clk);
        wait_cnt++;
      end while (!edge_ready_o && wait_cnt < TIMEOUT);
      if (!edge_ready_o) begin
        log_failure("edge was not accepted within the timeout");
        edge_q.delete();
      end else begin
        void'(edge_q.pop_front());
      end
      #1;
    end
    edge_valid_i = 1'b0;
  endtask

  task automatic collect_coefs(input int n);
    int wait_cnt;
    int exp_coef;
    repeat (n) begin
      wait_cnt = 0;
      do begin
        @(posedge clk);
        wait_cnt++;
      end while (!(coef_valid_o && coef_ready_i) && wait_cnt < TIMEOUT);
      exp_coef = exp_q.pop_front();
      if (!(coef_valid_o && coef_ready_i)) begin
        log_failure("no coefficient arrived within the timeout");
      end else begin
        rx_count++;
        if (coef_o !== exp_coef[SCORE_W-1:0]) report_mismatch("coef_o", exp_coef, coef_o);
      end
    end
    #1;
  endtask

  task automatic run_edges();
    int n;
    n = edge_q.size();
    fork
      send_edges();
      collect_coefs(n);
    join
  endtask

  // Enable is cleared, so the edge must stay blocked
  task automatic offer_blocked_edge(input logic [2*VEC_W-1:0] data);
    {edge_self_i, edge_neigh_i} = data;
    edge_valid_i = 1'b1;
    repeat (BLOCK_CYCLES) begin
      @(posedge clk);
      if (edge_ready_o !== 1'b0) report_mismatch("edge_ready_o", 0, edge_ready_o);
      if (coef_valid_o !== 1'b0) report_mismatch("coef_valid_o", 0, coef_valid_o);
    end
    #1;
    edge_valid_i = 1'b0;
  endtask

  // Self entries come first and land in the upper half
  task automatic read_edge(input int fd, output logic [2*VEC_W-1:0] data);
    int v;
    int r;
    data = '0;
    for (int i = 0; i < 2 * NUM_FEATURE; i++) begin
      r = $fscanf(fd, "%d", v);
      if (r != 1) log_failure("edge line in the case file is incomplete");
      data[((i + NUM_FEATURE) % (2 * NUM_FEATURE)) * FEAT_W +: FEAT_W] = v[FEAT_W-1:0];
    end
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    int fd;
    int c;
    int r;
    int addr;
    int data;
    int err;
    int coef;
    logic [8*256-1:0]   skip;
    logic [2*VEC_W-1:0] packed_edge;

    paddr_i      = '0;
    psel_i       = 1'b0;
    penable_i    = 1'b0;
    pwrite_i     = 1'b0;
    pwdata_i     = '0;
    edge_valid_i = 1'b0;
    edge_self_i  = '0;
    edge_neigh_i = '0;
    coef_ready_i = 1'b0;
    rst_n        = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (edge_ready_o !== 1'b0) report_mismatch("edge_ready_o", 0, edge_ready_o);
    if (coef_valid_o !== 1'b0) report_mismatch("coef_valid_o", 0, coef_valid_o);
    if (pslverr_o !== 1'b0) report_mismatch("pslverr_o", 0, pslverr_o);

    fd = $fopen("sim/gat_attn_cases.txt", "r");
    if (fd == 0) begin
      log_failure("cannot open sim/gat_attn_cases.txt");
    end else begin
      while ($fscanf(fd, " %c", c) == 1) begin
        if (c != "E" && c != "#" && edge_q.size() > 0) run_edges();
        case (c)
          "#": r = $fgets(skip, fd);
          "W": begin
            r = $fscanf(fd, "%h %h %h", addr, data, err);
            if (r != 3) log_failure("APB write line in the case file is incomplete");
            apb_access(1'b1, addr, data, '0, err);
          end
          "R": begin
            r = $fscanf(fd, "%h %h %h", addr, data, err);
            if (r != 3) log_failure("APB read line in the case file is incomplete");
            apb_access(1'b0, addr, '0, data, err);
          end
          "E": begin
            read_edge(fd, packed_edge);
            r = $fscanf(fd, "%d", coef);
            if (r != 1) log_failure("edge line in the case file has no coefficient");
            edge_q.push_back(packed_edge);
            exp_q.push_back(coef);
          end
          "H": begin
            read_edge(fd, packed_edge);
            offer_blocked_edge(packed_edge);
          end
          "C": apb_access(1'b0, COUNT_ADDR, '0, rx_count, 1'b0);
          default: begin
            log_failure("unknown command in the case file");
            r = $fgets(skip, fd);
          end
        endcase
      end
      if (edge_q.size() > 0) run_edges();
      $fclose(fd);
    end

    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/gat_pkg.sv
rtl/gat_apb_regs.sv
rtl/gat_score_unit.sv
rtl/gat_coef_combine.sv
rtl/gat_attn_top.sv
sim/gat_attn_tb.sv
